// File: common/udp_msg_pkg.sv
// **************************************************
// shared types and constants for the UDP reply engine
// field types, reply header values, message table
// **************************************************

package udp_msg_pkg;

    // header field types
    typedef logic [31:0] ip_addr_t;   // ipv4 address
    typedef logic [15:0] port_t;      // udp port number
    typedef logic [15:0] len_t;       // udp length field
    typedef logic [7:0]  ttl_t;       // ip time-to-live
    typedef logic [7:0]  byte_t;      // one payload byte
    typedef logic [3:0]  msg_idx_t;   // index into the message table

    // this node, 192.168.1.128
    localparam ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // requests must target this port, replies also leave from it
    localparam port_t SERVICE_PORT    = 16'h1234;
    localparam port_t REPLY_DEST_PORT = 16'h5678;

    localparam ttl_t REPLY_TTL = 8'd64;

    // udp length covers header plus payload
    localparam int UDP_HDR_LEN = 8;
    localparam int MSG_LEN     = 12;
    localparam len_t REPLY_LEN = len_t'(UDP_HDR_LEN + MSG_LEN);   // 20

    // reply payload, sent first to last
    localparam byte_t MSG_BYTES [MSG_LEN] = '{
        8'h55,   // first byte, also shown on the leds
        8'h68,
        8'h65,
        8'h6C,
        8'h6C,
        8'h6F,
        8'h20,
        8'h77,
        8'h6F,
        8'h72,
        8'h6C,
        8'h64    // last byte, tx_last goes with it
    };

endpackage

// File: logic/message_streamer.sv
// **************************************************
// message streamer for the reply payload
// walks the message table one byte per transfer
// and flags the final byte
// **************************************************

module message_streamer import udp_msg_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // one pulse per accepted payload transfer
    input  logic  msg_advance,

    // current byte, always available
    output byte_t msg_data,
    output logic  msg_last
);

    localparam msg_idx_t LAST_IDX = msg_idx_t'(MSG_LEN - 1);

    msg_idx_t idx;   // byte counter into MSG_BYTES

    // table lookup at the current position
    assign msg_data = MSG_BYTES[idx];
    assign msg_last = (idx == LAST_IDX);

    // each reply ends on the last byte
    // so the wrap leaves the next reply at byte 0
    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
        end else if (msg_advance) begin
            if (msg_last) begin
                idx <= '0;                 // wrap after the final byte
            end else begin
                idx <= idx + msg_idx_t'(1);
            end
        end
    end

endmodule

// File: logic/reply_sequencer.sv
// **************************************************
// reply sequencer, one reply at a time
// header first, then MSG_LEN payload bytes
// first payload byte latched onto the leds
// **************************************************

module reply_sequencer import udp_msg_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // pending request from the filter
    input  logic     req_valid,
    output logic     req_ready,
    input  ip_addr_t req_ip,

    // message streamer
    input  byte_t    msg_data,
    input  logic     msg_last,
    output logic     msg_advance,

    // reply header toward the stack
    output logic     tx_hdr_valid,
    input  logic     tx_hdr_ready,
    output ip_addr_t tx_source_ip,
    output ip_addr_t tx_dest_ip,
    output port_t    tx_source_port,
    output port_t    tx_dest_port,
    output len_t     tx_length,
    output ttl_t     tx_ttl,

    // reply payload toward the stack
    output byte_t    tx_data,
    output logic     tx_valid,
    input  logic     tx_ready,
    output logic     tx_last,

    output byte_t    led
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_PAYLOAD
    } state_t;

    state_t   state;
    logic     first_byte;   // next payload transfer is byte 0
    ip_addr_t dest_ip;      // requester of the reply in flight
    logic     req_take;
    logic     hdr_take;
    byte_t    led_reg;

    assign req_ready = (state == ST_IDLE);
    assign req_take  = req_valid && req_ready;
    assign hdr_take  = tx_hdr_valid && tx_hdr_ready;

    // header fields, only the destination varies
    assign tx_hdr_valid   = (state == ST_HDR);
    assign tx_source_ip   = LOCAL_IP;
    assign tx_dest_ip     = dest_ip;
    assign tx_source_port = SERVICE_PORT;
    assign tx_dest_port   = REPLY_DEST_PORT;
    assign tx_length      = REPLY_LEN;       // 8 header + 12 message bytes
    assign tx_ttl         = REPLY_TTL;

    // payload passes straight from the streamer
    assign tx_valid    = (state == ST_PAYLOAD);
    assign tx_data     = msg_data;
    assign tx_last     = tx_valid && msg_last;
    assign msg_advance = tx_valid && tx_ready;   // one strobe per byte

    assign led = led_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            first_byte <= 1'b0;
            led_reg    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_take) state <= ST_HDR;   // header valid next cycle
                end
                ST_HDR: begin
                    if (hdr_take) begin
                        state      <= ST_PAYLOAD;
                        first_byte <= 1'b1;
                    end
                end
                ST_PAYLOAD: begin
                    if (msg_advance) begin
                        if (first_byte) led_reg <= tx_data;   // byte 0 onto leds
                        first_byte <= 1'b0;
                        if (msg_last) state <= ST_IDLE;      // reply done
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // requester address, captured with the request
    always_ff @(posedge clk) begin
        if (req_take) begin
            dest_ip <= req_ip;
        end
    end

endmodule

// File: logic/request_filter.sv
// **************************************************
// request filter on the received udp header stream
// keeps headers for the service port, holds one
// pending request for the reply sequencer
// **************************************************

module request_filter import udp_msg_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // received udp header from the stack
    input  logic     rx_hdr_valid,
    output logic     rx_hdr_ready,
    input  port_t    rx_dest_port,
    input  ip_addr_t rx_source_ip,

    // pending request toward the sequencer
    output logic     req_valid,
    input  logic     req_ready,
    output ip_addr_t req_ip
);

    logic     held;       // one request waiting
    ip_addr_t held_ip;    // requester address of that request
    logic     hdr_take;   // header transfer this cycle
    logic     port_match;

    assign port_match = (rx_dest_port == SERVICE_PORT);
    assign hdr_take   = rx_hdr_valid && rx_hdr_ready;

    // accept anything while empty, mismatches just vanish
    assign rx_hdr_ready = !held;

    assign req_valid = held;
    assign req_ip    = held_ip;

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (hdr_take && port_match) begin
            held <= 1'b1;                  // req_valid next cycle
        end else if (req_valid && req_ready) begin
            held <= 1'b0;                  // handed over to the sequencer
        end
    end

    // requester address of a matching header
    always_ff @(posedge clk) begin
        if (hdr_take && port_match) begin
            held_ip <= rx_source_ip;       // reply goes back here
        end
    end

endmodule

// File: logic/udp_msg_core.sv
// **************************************************
// udp reply engine top level
// request filter, message streamer, reply sequencer
// **************************************************

module udp_msg_core import udp_msg_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // received udp header
    input  logic     rx_hdr_valid,
    output logic     rx_hdr_ready,
    input  port_t    rx_dest_port,
    input  ip_addr_t rx_source_ip,

    // reply header
    output logic     tx_hdr_valid,
    input  logic     tx_hdr_ready,
    output ip_addr_t tx_source_ip,
    output ip_addr_t tx_dest_ip,
    output port_t    tx_source_port,
    output port_t    tx_dest_port,
    output len_t     tx_length,
    output ttl_t     tx_ttl,

    // reply payload
    output byte_t    tx_data,
    output logic     tx_valid,
    input  logic     tx_ready,
    output logic     tx_last,

    output byte_t    led
);

    // filter to sequencer
    logic     req_valid;
    logic     req_ready;
    ip_addr_t req_ip;

    // streamer to sequencer and back
    byte_t    msg_data;
    logic     msg_last;
    logic     msg_advance;

    request_filter request_filter_inst (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_dest_port (rx_dest_port),
        .rx_source_ip (rx_source_ip),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_ip       (req_ip)
    );

    message_streamer message_streamer_inst (
        .clk         (clk),
        .rst         (rst),
        .msg_advance (msg_advance),
        .msg_data    (msg_data),
        .msg_last    (msg_last)
    );

    reply_sequencer reply_sequencer_inst (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_ip         (req_ip),
        .msg_data       (msg_data),
        .msg_last       (msg_last),
        .msg_advance    (msg_advance),
        .tx_hdr_valid   (tx_hdr_valid),
        .tx_hdr_ready   (tx_hdr_ready),
        .tx_source_ip   (tx_source_ip),
        .tx_dest_ip     (tx_dest_ip),
        .tx_source_port (tx_source_port),
        .tx_dest_port   (tx_dest_port),
        .tx_length      (tx_length),
        .tx_ttl         (tx_ttl),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .tx_last        (tx_last),
        .led            (led)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the udp reply engine testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module tb_udp_msg_core -o sim_tb

# the log decides, the model exit status is not used
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Test passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported a failure"
    exit 1
fi

// File: verif/tb_udp_msg_tasks.svh
// **************************************************
// expected reply values, header driver, reply
// collector, typed compare tasks, directed tests
// **************************************************

`ifndef TB_UDP_MSG_TASKS_SVH
`define TB_UDP_MSG_TASKS_SVH

// reply as the protocol defines it
localparam ip_addr_t EXP_SRC_IP   = {8'd192, 8'd168, 8'd1, 8'd128};
localparam port_t    EXP_SRC_PORT = 16'h1234;   // service port, replies leave from it
localparam port_t    EXP_DST_PORT = 16'h5678;
localparam len_t     EXP_LEN      = 16'd20;     // 8 header + 12 message
localparam ttl_t     EXP_TTL      = 8'd64;
localparam msg_idx_t EXP_MSG_LEN  = 4'd12;
localparam byte_t    EXP_MSG [12] = '{8'h55, 8'h68, 8'h65, 8'h6C, 8'h6C, 8'h6F,
                                      8'h20, 8'h77, 8'h6F, 8'h72, 8'h6C, 8'h64};

int replies_done = 0;   // bumped as each final byte is accepted

task automatic abort_run();
    $display("Test failed");
    $fatal(1, "run stopped at the first error");
endtask

task automatic check_ip(input string name, input ip_addr_t exp, input ip_addr_t act);
    if (act !== exp) begin
        $display("ERR %s expected 0x%08h got 0x%08h", name, exp, act);
        abort_run();
    end
endtask

task automatic check_port(input string name, input port_t exp, input port_t act);
    if (act !== exp) begin
        $display("ERR %s expected 0x%04h got 0x%04h", name, exp, act);
        abort_run();
    end
endtask

task automatic check_len(input string name, input len_t exp, input len_t act);
    if (act !== exp) begin
        $display("ERR %s expected 0x%04h got 0x%04h", name, exp, act);
        abort_run();
    end
endtask

task automatic check_ttl(input string name, input ttl_t exp, input ttl_t act);
    if (act !== exp) begin
        $display("ERR %s expected 0x%02h got 0x%02h", name, exp, act);
        abort_run();
    end
endtask

task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
        $display("ERR %s expected 0x%02h got 0x%02h", name, exp, act);
        abort_run();
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s expected 0x%0h got 0x%0h", name, exp, act);
        abort_run();
    end
endtask

// called on a falling edge, returns on one
task automatic offer_header(input port_t port, input ip_addr_t ip);
    rx_hdr_valid = 1'b1;
    rx_dest_port = port;
    rx_source_ip = ip;
    while (!rx_hdr_ready) @(negedge clk);   // held until the filter has room
    @(negedge clk);                          // taken on the rising edge just passed
    rx_hdr_valid = 1'b0;
endtask

// one full reply, header then every message byte in order
task automatic collect_reply(input ip_addr_t exp_ip, input bit random_stall,
                             input int hold_cycles);
    msg_idx_t count;
    bit       got_hdr;
    logic     rdy;
    count        = '0;
    got_hdr      = 1'b0;
    tx_hdr_ready = 1'b0;
    tx_ready     = 1'b0;
    repeat (hold_cycles) @(negedge clk);     // stack busy
    while (!got_hdr) begin
        rdy          = random_stall ? (($urandom % 2) == 1) : 1'b1;
        tx_hdr_ready = rdy;
        check_flag("tx_valid", 1'b0, tx_valid);   // no payload before the header
        if (tx_hdr_valid && rdy) begin
            check_ip("tx_source_ip", EXP_SRC_IP, tx_source_ip);
            check_ip("tx_dest_ip", exp_ip, tx_dest_ip);
            check_port("tx_source_port", EXP_SRC_PORT, tx_source_port);
            check_port("tx_dest_port", EXP_DST_PORT, tx_dest_port);
            check_len("tx_length", EXP_LEN, tx_length);
            check_ttl("tx_ttl", EXP_TTL, tx_ttl);
            got_hdr = 1'b1;
        end
        @(negedge clk);
    end
    tx_hdr_ready = 1'b0;
    while (count < EXP_MSG_LEN) begin
        rdy      = random_stall ? (($urandom % 2) == 1) : 1'b1;
        tx_ready = rdy;
        check_flag("tx_hdr_valid", 1'b0, tx_hdr_valid);   // one header per reply
        if (tx_valid && rdy) begin
            check_byte("tx_data", EXP_MSG[count], tx_data);
            check_flag("tx_last", count == EXP_MSG_LEN - 4'd1, tx_last);
            count = count + 4'd1;
        end
        if (count == EXP_MSG_LEN) replies_done++;   // final byte goes on this edge
        @(negedge clk);
    end
    tx_ready = 1'b0;
    check_flag("tx_valid", 1'b0, tx_valid);   // back to idle, nothing extra
endtask

task automatic after_reset();
    check_flag("tx_hdr_valid", 1'b0, tx_hdr_valid);
    check_flag("tx_valid", 1'b0, tx_valid);
    check_flag("rx_hdr_ready", 1'b1, rx_hdr_ready);
    check_byte("led", 8'h00, led);
endtask

task automatic single_reply(input ip_addr_t ip);
    offer_header(EXP_SRC_PORT, ip);
    collect_reply(ip, 1'b0, 0);   // ready held high
    check_byte("led", EXP_MSG[0], led);
endtask

// wrong port, silently dropped
task automatic foreign_port_dropped(input ip_addr_t ip);
    offer_header(16'h4321, ip);
    tx_hdr_ready = 1'b1;
    repeat (50) begin
        check_flag("tx_hdr_valid", 1'b0, tx_hdr_valid);
        check_flag("rx_hdr_ready", 1'b1, rx_hdr_ready);
        @(negedge clk);
    end
    tx_hdr_ready = 1'b0;
endtask

task automatic stalled_reply(input ip_addr_t ip);
    offer_header(EXP_SRC_PORT, ip);
    collect_reply(ip, 1'b1, 0);
endtask

// a in the sequencer, b in the filter, c blocked
task automatic queued_requests(input ip_addr_t ip_a, input ip_addr_t ip_b,
                               input ip_addr_t ip_c);
    replies_done = 0;
    fork
        begin
            offer_header(EXP_SRC_PORT, ip_a);
            offer_header(EXP_SRC_PORT, ip_b);
            offer_header(EXP_SRC_PORT, ip_c);
            if (replies_done == 0) begin
                $display("third request was accepted while the first reply was still open");
                abort_run();
            end
        end
        begin
            collect_reply(ip_a, 1'b1, 20);   // first header stalled long
            collect_reply(ip_b, 1'b1, 0);
            collect_reply(ip_c, 1'b1, 0);
        end
    join
    check_byte("led", EXP_MSG[0], led);
endtask

`endif

// File: verif/tb_udp_msg_core.sv
// **************************************************
// testbench top for the udp reply engine
// clock, reset, DUT instance, timeout counter
// and the order of the directed tests
// **************************************************

module tb_udp_msg_core import udp_msg_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 3000;   // five tests, a few hundred cycles each at most

    // requester addresses
    localparam ip_addr_t IP_A = 32'h0A00_0005;   // 10.0.0.5
    localparam ip_addr_t IP_B = 32'hC0A8_0107;   // 192.168.1.7
    localparam ip_addr_t IP_C = 32'hAC10_2233;   // 172.16.34.51

    logic     clk;
    logic     rst;

    // received header, driven here
    logic     rx_hdr_valid;
    logic     rx_hdr_ready;
    port_t    rx_dest_port;
    ip_addr_t rx_source_ip;

    // reply header and payload from the DUT
    logic     tx_hdr_valid;
    logic     tx_hdr_ready;
    ip_addr_t tx_source_ip;
    ip_addr_t tx_dest_ip;
    port_t    tx_source_port;
    port_t    tx_dest_port;
    len_t     tx_length;
    ttl_t     tx_ttl;
    byte_t    tx_data;
    logic     tx_valid;
    logic     tx_ready;
    logic     tx_last;
    byte_t    led;

    int       cycle_count = 0;   // clock cycles since time 0

    udp_msg_core udp_msg_core_inst (.*);

    `include "tb_udp_msg_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // period 8
    end

    // hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never finished a reply", cycle_count);
            abort_run();
        end
    end

    initial begin
        void'($urandom(33));   // fixed seed for the stall patterns
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_dest_port = '0;
        rx_source_ip = '0;
        tx_hdr_ready = 1'b0;
        tx_ready     = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;          // tests start on a falling edge

        after_reset();
        single_reply(IP_A);
        foreign_port_dropped(IP_B);
        stalled_reply(IP_C);
        queued_requests(IP_A, IP_B, IP_C);

        $display("Test passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verif
common/udp_msg_pkg.sv
logic/request_filter.sv
logic/message_streamer.sv
logic/reply_sequencer.sv
logic/udp_msg_core.sv
verif/tb_udp_msg_core.sv
